//--- sources.f
hdl/fetch_pkg.sv
hdl/addr_xlate.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/fetch_top.sv
test/inst_mem_model.sv
test/fetch_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb \
    -f sources.f -o fetch_sim > build.log 2>&1 \
    && ./obj_dir/fetch_sim > sim.log 2>&1
grep -qsx "test passed" sim.log && echo "PASS" \
    || { echo "FAIL, see build.log and sim.log"; exit 1; }

//--- test/fetch_tb.sv
module fetch_tb;

    localparam fetch_pkg::addr_t WINDOW_VA_BASE = 32'h1c000000;
    localparam fetch_pkg::addr_t WINDOW_PA_BASE = 32'h00000000;
    localparam int WINDOW_BITS = 16;
    localparam int OUT_TIMEOUT = 400;

    logic                   clk;
    logic                   resetn;
    logic                   inst_sram_req;
    fetch_pkg::addr_t       inst_sram_addr;
    fetch_pkg::inst_t       inst_sram_rdata;
    logic                   inst_sram_addr_ok;
    logic                   inst_sram_data_ok;
    logic                   flush;
    fetch_pkg::addr_t       flush_pc;
    logic                   out_valid;
    fetch_pkg::decode_bus_t out_bus;
    logic                   out_allowin;

    int                     seed;
    int                     n_out;
    fetch_pkg::addr_t       exp_pc;
    logic                   held;
    fetch_pkg::decode_bus_t held_bus;
    logic                   reset_seen;

    fetch_top #(
        .window_va_base (WINDOW_VA_BASE),
        .window_pa_base (WINDOW_PA_BASE),
        .window_bits    (WINDOW_BITS)
    ) dut0 (
        .clk               (clk),
        .resetn            (resetn),
        .inst_sram_req     (inst_sram_req),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .inst_sram_data_ok (inst_sram_data_ok),
        .flush             (flush),
        .flush_pc          (flush_pc),
        .out_valid         (out_valid),
        .out_bus           (out_bus),
        .out_allowin       (out_allowin)
    );

    inst_mem_model mem0 (
        .clk     (clk),
        .resetn  (resetn),
        .req     (inst_sram_req),
        .addr    (inst_sram_addr),
        .addr_ok (inst_sram_addr_ok),
        .data_ok (inst_sram_data_ok),
        .rdata   (inst_sram_rdata)
    );

    always #2 clk = ~clk;

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1);
    endtask

    function automatic fetch_pkg::addr_t translate(input fetch_pkg::addr_t va);
        return WINDOW_PA_BASE + (va & ((32'h1 << WINDOW_BITS) - 32'h1));
    endfunction

    function automatic logic outside_window(input fetch_pkg::addr_t va);
        return (va >> WINDOW_BITS) != (WINDOW_VA_BASE >> WINDOW_BITS);
    endfunction

    task automatic wait_outputs(input int n);
        int target;
        int cycles;
        target = n_out + n;
        cycles = 0;
        while (n_out < target && cycles < OUT_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (n_out < target) begin
            stop_with_error($sformatf("timeout waiting for %0d outputs", n));
        end
    endtask

    // returns at the edge that closes an accepted request
    task automatic wait_request_accept();
        int cycles;
        logic seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < OUT_TIMEOUT) begin
            @(posedge clk);
            seen = inst_sram_req && inst_sram_addr_ok;
            cycles++;
        end
        if (!seen) begin
            stop_with_error("timeout waiting for an accepted memory request");
        end
    endtask

    task automatic pulse_flush(input fetch_pkg::addr_t pc);
        flush    <= 1'b1;
        flush_pc <= pc;
        @(posedge clk);
        flush    <= 1'b0;
    endtask

    // downstream stalls about a quarter of the time
    always @(posedge clk) begin
        out_allowin <= resetn && (($random(seed) & 3) != 0);
    end

    always @(posedge clk) begin : check_outputs
        fetch_pkg::inst_t word;
        logic             fault;
        logic             br_word;
        int               offs;
        if (!resetn) begin
            // synchronous reset holds from the first edge on
            if (reset_seen) begin
                assert (!inst_sram_req && !out_valid) else stop_with_error($sformatf(
                    "Mismatch inst_sram_req %h out_valid %h in reset, expected 0",
                    inst_sram_req, out_valid));
            end
            reset_seen <= 1'b1;
            held       <= 1'b0;
            exp_pc = 32'h1c000000;
        end else begin
            if (held) begin
                assert (out_valid) else stop_with_error(
                    "Mismatch out_valid got 0 expected 1 while stalled");
                assert (out_bus == held_bus) else stop_with_error($sformatf(
                    "Mismatch out_bus got %h expected %h", out_bus, held_bus));
            end
            held     <= out_valid && !out_allowin && !flush;
            held_bus <= out_bus;
            if (flush) begin
                exp_pc = flush_pc;
            end else if (out_valid && out_allowin) begin
                word    = mem0.word_at(translate(exp_pc));
                fault   = outside_window(exp_pc) || (exp_pc[1:0] != 2'b00);
                br_word = word[31:26] == fetch_pkg::BR_OPCODE;
                assert (out_bus.pc == exp_pc) else stop_with_error($sformatf(
                    "Mismatch out_bus.pc got %h expected %h", out_bus.pc, exp_pc));
                assert (out_bus.inst == word) else stop_with_error($sformatf(
                    "Mismatch out_bus.inst got %h expected %h", out_bus.inst, word));
                assert (out_bus.xfault == outside_window(exp_pc)) else stop_with_error(
                    $sformatf("Mismatch out_bus.xfault got %h expected %h",
                    out_bus.xfault, outside_window(exp_pc)));
                assert (out_bus.adef == (exp_pc[1:0] != 2'b00)) else stop_with_error(
                    $sformatf("Mismatch out_bus.adef got %h expected %h",
                    out_bus.adef, exp_pc[1:0] != 2'b00));
                assert (out_bus.is_branch == br_word) else stop_with_error($sformatf(
                    "Mismatch out_bus.is_branch got %h expected %h",
                    out_bus.is_branch, br_word));
                // only a clean branch steers the stream
                if (br_word && !fault) begin
                    offs   = $signed(word[25:0]);
                    exp_pc = exp_pc + fetch_pkg::addr_t'(offs * 4);
                end else begin
                    exp_pc = exp_pc + 32'd4;
                end
                n_out <= n_out + 1;
            end
        end
    end

    initial begin
        clk         = 1'b0;
        resetn      = 1'b0;
        flush       = 1'b0;
        flush_pc    = '0;
        out_allowin = 1'b0;
        seed        = 32'h3d22;
        n_out       = 0;
        reset_seen  = 1'b0;
        repeat (10) @(posedge clk);
        resetn <= 1'b1;

        // straight line code and the branch loop
        wait_outputs(40);

        // flushes while a fetch is in flight
        repeat (8) begin
            wait_request_accept();
            pulse_flush(WINDOW_VA_BASE + ($random(seed) & 32'h1ffc));
            wait_outputs(6);
        end

        // faulting fetches land on a branch word
        pulse_flush(32'h2c000018);
        wait_outputs(4);
        pulse_flush(32'h1c000019);
        wait_outputs(4);

        $display("test passed");
        $finish;
    end

endmodule

//--- test/inst_mem_model.sv
module inst_mem_model #(
    parameter int image_words = 1024
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             req,
    input  fetch_pkg::addr_t addr,
    output logic             addr_ok,
    output logic             data_ok,
    output fetch_pkg::inst_t rdata
);

    fetch_pkg::addr_t pending[$];
    int seed;
    int accept_wait;
    int return_wait;

    function automatic fetch_pkg::inst_t branch_word(input int words);
        return {fetch_pkg::BR_OPCODE, 26'(words)};
    endfunction

    // program image, branches form a loop 0..6 -> 16..20 -> 120..130 -> 5
    function automatic fetch_pkg::inst_t word_at(input fetch_pkg::addr_t pa);
        int idx;
        idx = int'(pa >> 2);
        if (idx >= image_words) begin
            return 32'hc3000000 ^ pa;
        end
        case (idx)
            6:       return branch_word(10);
            20:      return branch_word(100);
            130:     return branch_word(-125);
            default: return 32'h00100000 + pa;
        endcase
    endfunction

    initial begin
        seed    = 32'h3d22;
        addr_ok = 1'b0;
        data_ok = 1'b0;
        rdata   = '0;
    end

    always @(posedge clk) begin
        if (!resetn) begin
            addr_ok <= 1'b0;
            data_ok <= 1'b0;
            pending.delete();
            accept_wait = 0;
            return_wait = 0;
        end else begin
            if (req && addr_ok) begin
                pending.push_back(addr);
                accept_wait = $random(seed) & 3;
            end
            // gap of 0 to 3 cycles before the next accept
            if (accept_wait > 0) begin
                accept_wait = accept_wait - 1;
                addr_ok <= 1'b0;
            end else begin
                addr_ok <= 1'b1;
            end
            data_ok <= 1'b0;
            if (pending.size() > 0) begin
                if (return_wait > 0) begin
                    return_wait = return_wait - 1;
                end else begin
                    data_ok <= 1'b1;
                    rdata   <= word_at(pending[0]);
                    pending.delete(0);
                    return_wait = $random(seed) & 3;
                end
            end
        end
    end

endmodule

//--- hdl/fetch_top.sv
module fetch_top #(
    parameter fetch_pkg::addr_t window_va_base = 32'h1c000000,
    parameter fetch_pkg::addr_t window_pa_base = 32'h00000000,
    parameter int window_bits = 16
) (
    input  logic                   clk,
    input  logic                   resetn,
    // instruction memory port
    output logic                   inst_sram_req,
    output fetch_pkg::addr_t       inst_sram_addr,
    input  fetch_pkg::inst_t       inst_sram_rdata,
    input  logic                   inst_sram_addr_ok,
    input  logic                   inst_sram_data_ok,
    // writeback flush
    input  logic                   flush,
    input  fetch_pkg::addr_t       flush_pc,
    // downstream
    output logic                   out_valid,
    output fetch_pkg::decode_bus_t out_bus,
    input  logic                   out_allowin
);

    fetch_pkg::addr_t        inst_va;
    fetch_pkg::addr_t        inst_pa;
    logic                    xfault;
    logic                    fs_to_ds_valid;
    fetch_pkg::fetch_bus_t   fs_to_ds_bus;
    logic                    ds_allowin;
    fetch_pkg::br_redirect_t br;

    addr_xlate #(
        .window_va_base (window_va_base),
        .window_pa_base (window_pa_base),
        .window_bits    (window_bits)
    ) xlate0 (
        .va     (inst_va),
        .pa     (inst_pa),
        .xfault (xfault)
    );

    fetch_stage fs0 (
        .clk               (clk),
        .resetn            (resetn),
        .inst_sram_req     (inst_sram_req),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_va           (inst_va),
        .inst_pa           (inst_pa),
        .xfault            (xfault),
        .ds_allowin        (ds_allowin),
        .br                (br),
        .fs_to_ds_valid    (fs_to_ds_valid),
        .fs_to_ds_bus      (fs_to_ds_bus),
        .flush             (flush),
        .flush_pc          (flush_pc)
    );

    decode_stage ds0 (
        .clk            (clk),
        .resetn         (resetn),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .ds_allowin     (ds_allowin),
        .br             (br),
        .flush          (flush),
        .out_valid      (out_valid),
        .out_bus        (out_bus),
        .out_allowin    (out_allowin)
    );

endmodule

//--- hdl/decode_stage.sv
module decode_stage (
    input  logic                    clk,
    input  logic                    resetn,
    // from fetch
    input  logic                    fs_to_ds_valid,
    input  fetch_pkg::fetch_bus_t   fs_to_ds_bus,
    output logic                    ds_allowin,
    output fetch_pkg::br_redirect_t br,
    // writeback flush
    input  logic                    flush,
    // downstream
    output logic                    out_valid,
    output fetch_pkg::decode_bus_t  out_bus,
    input  logic                    out_allowin
);

    logic                  ds_valid;
    fetch_pkg::fetch_bus_t ds_bus;
    fetch_pkg::opcode_t    opcode;
    logic                  is_branch;
    logic                  br_ok;
    fetch_pkg::addr_t      br_offs;

    assign ds_allowin = ~ds_valid | out_allowin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ds_valid <= 1'b0;
        end else if (flush) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid & ds_allowin) begin
            ds_bus <= fs_to_ds_bus;
        end
    end

    assign opcode    = ds_bus.inst[31:26];
    assign is_branch = opcode == fetch_pkg::BR_OPCODE;

    // word offset, sign extended
    assign br_offs = {{4{ds_bus.inst[25]}}, ds_bus.inst[25:0], 2'b00};

    // a faulting fetch never steers the stream
    assign br_ok = is_branch & ~ds_bus.adef & ~ds_bus.xfault;

    // pulse while the branch leaves
    assign br.taken  = ds_valid & br_ok & out_allowin;
    assign br.target = ds_bus.pc + br_offs;

    assign out_valid = ds_valid;

    always_comb begin
        out_bus.adef      = ds_bus.adef;
        out_bus.xfault    = ds_bus.xfault;
        out_bus.is_branch = is_branch;
        out_bus.inst      = ds_bus.inst;
        out_bus.pc        = ds_bus.pc;
    end

endmodule

//--- hdl/fetch_stage.sv
module fetch_stage (
    input  logic                   clk,
    input  logic                   resetn,
    // instruction memory port
    output logic                   inst_sram_req,
    output fetch_pkg::addr_t       inst_sram_addr,
    input  fetch_pkg::inst_t       inst_sram_rdata,
    input  logic                   inst_sram_addr_ok,
    input  logic                   inst_sram_data_ok,
    // address translation
    output fetch_pkg::addr_t       inst_va,
    input  fetch_pkg::addr_t       inst_pa,
    input  logic                   xfault,
    // decode
    input  logic                   ds_allowin,
    input  fetch_pkg::br_redirect_t br,
    output logic                   fs_to_ds_valid,
    output fetch_pkg::fetch_bus_t  fs_to_ds_bus,
    // writeback flush
    input  logic                   flush,
    input  fetch_pkg::addr_t       flush_pc
);

    localparam int CANCEL_W = 3;

    logic                  fetch_en;
    logic                  fs_valid;
    logic                  fs_ready_go;
    logic                  fs_allowin;
    logic                  to_fs_valid;
    logic                  req_accept;
    logic                  redirect;

    fetch_pkg::addr_t      fs_pc;
    logic                  fs_xfault;
    fetch_pkg::addr_t      seq_pc;
    fetch_pkg::addr_t      nextpc;

    logic                  redir_valid;
    fetch_pkg::addr_t      redir_pc;

    logic [CANCEL_W-1:0]   cancel_cnt;
    logic                  inst_cancel;
    logic                  cnt_inc;
    logic                  cnt_dec;
    logic                  pf_cancel;

    logic                  buf_valid;
    logic                  buf_load;
    fetch_pkg::inst_t      inst_buf;
    fetch_pkg::inst_t      fs_inst;

    assign redirect   = flush | br.taken;
    assign req_accept = inst_sram_req & inst_sram_addr_ok;

    // a request taken in a redirect cycle is dropped and reissued from the latch
    assign to_fs_valid = req_accept & ~redirect;

    assign inst_cancel = |cancel_cnt;
    assign fs_ready_go = buf_valid | (inst_sram_data_ok & ~inst_cancel);
    assign fs_allowin  = ~fs_valid | (fs_ready_go & ds_allowin);
    assign fs_to_ds_valid = fs_valid & fs_ready_go & ~redirect;

    assign inst_sram_req  = fetch_en & fs_allowin & ~pf_cancel;
    assign inst_sram_addr = inst_pa;

    // first request goes out the cycle after reset is released
    always_ff @(posedge clk) begin
        if (!resetn) begin
            fetch_en <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
        end
    end

    // pending redirect, flush takes priority
    always_ff @(posedge clk) begin
        if (!resetn) begin
            redir_valid <= 1'b0;
        end else if (flush) begin
            redir_valid <= 1'b1;
        end else if (br.taken) begin
            redir_valid <= 1'b1;
        end else if (req_accept) begin
            redir_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (flush) begin
            redir_pc <= flush_pc;
        end else if (br.taken) begin
            redir_pc <= br.target;
        end
    end

    assign seq_pc = fs_pc + fetch_pkg::PC_STEP;

    always_comb begin
        if (redir_valid) begin
            nextpc = redir_pc;
        end else if (flush) begin
            nextpc = flush_pc;
        end else if (br.taken) begin
            nextpc = br.target;
        end else begin
            nextpc = seq_pc;
        end
    end

    assign inst_va = nextpc;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            fs_valid <= 1'b0;
        end else if (fs_allowin) begin
            fs_valid <= to_fs_valid;
        end else if (redirect) begin
            fs_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            fs_pc     <= fetch_pkg::RESET_PC;
            fs_xfault <= 1'b0;
        end else if (to_fs_valid) begin
            fs_pc     <= nextpc;
            fs_xfault <= xfault;
        end
    end

    // responses still owed to fetches killed while waiting
    assign cnt_inc = redirect & fs_valid & ~fs_ready_go;
    assign cnt_dec = inst_sram_data_ok & inst_cancel;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cancel_cnt <= '0;
        end else if (cnt_inc & ~cnt_dec) begin
            cancel_cnt <= cancel_cnt + 1'b1;
        end else if (cnt_dec & ~cnt_inc) begin
            cancel_cnt <= cancel_cnt - 1'b1;
        end
    end

    // request accepted in a redirect cycle, newest in line
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pf_cancel <= 1'b0;
        end else if (req_accept & redirect) begin
            pf_cancel <= 1'b1;
        end else if (inst_sram_data_ok & ~inst_cancel) begin
            pf_cancel <= 1'b0;
        end
    end

    // hold the word while decode is full
    assign buf_load = fs_valid & ~buf_valid & inst_sram_data_ok & ~inst_cancel;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            buf_valid <= 1'b0;
        end else if (redirect | (fs_to_ds_valid & ds_allowin)) begin
            buf_valid <= 1'b0;
        end else if (buf_load) begin
            buf_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (buf_load) begin
            inst_buf <= inst_sram_rdata;
        end
    end

    assign fs_inst = buf_valid ? inst_buf : inst_sram_rdata;

    always_comb begin
        fs_to_ds_bus.adef   = |fs_pc[1:0];
        fs_to_ds_bus.xfault = fs_xfault;
        fs_to_ds_bus.inst   = fs_inst;
        fs_to_ds_bus.pc     = fs_pc;
    end

endmodule

//--- hdl/addr_xlate.sv
module addr_xlate #(
    parameter fetch_pkg::addr_t window_va_base = 32'h1c000000,
    parameter fetch_pkg::addr_t window_pa_base = 32'h00000000,
    parameter int window_bits = 16
) (
    input  fetch_pkg::addr_t va,
    output fetch_pkg::addr_t pa,
    output logic             xfault
);

    // low bits pass through as the window offset
    localparam fetch_pkg::addr_t OFFSET_MASK =
        (fetch_pkg::addr_t'(1) << window_bits) - fetch_pkg::addr_t'(1);

    // page that a va inside the window carries
    localparam fetch_pkg::addr_t BASE_PAGE = window_va_base & ~OFFSET_MASK;

    fetch_pkg::addr_t offset;
    fetch_pkg::addr_t va_page;

    assign offset  = va & OFFSET_MASK;
    assign va_page = va & ~OFFSET_MASK;

    // outside the window the address is still formed and only flagged
    assign xfault = va_page != BASE_PAGE;
    assign pa     = window_pa_base + offset;

endmodule

//--- hdl/fetch_pkg.sv
package fetch_pkg;

    localparam int ADDR_W = 32;
    localparam int INST_W = 32;
    localparam int OPCODE_W = 6;

    // virtual or physical byte address
    typedef logic [ADDR_W-1:0] addr_t;

    // raw instruction word
    typedef logic [INST_W-1:0] inst_t;

    // major opcode field, bits 31..26
    typedef logic [OPCODE_W-1:0] opcode_t;

    // fetch pc after reset, one word before the boot address
    localparam addr_t RESET_PC = 32'h1bfffffc;

    localparam addr_t PC_STEP = 32'd4;

    // relative branch, offset in bits 25..0
    localparam opcode_t BR_OPCODE = 6'b010100;

    // decode to fetch redirect
    typedef struct packed {
        logic  taken;
        addr_t target;
    } br_redirect_t;

    // fetch to decode
    typedef struct packed {
        logic  adef;
        logic  xfault;
        inst_t inst;
        addr_t pc;
    } fetch_bus_t;

    // decode to the next stage
    typedef struct packed {
        logic  adef;
        logic  xfault;
        logic  is_branch;
        inst_t inst;
        addr_t pc;
    } decode_bus_t;

endpackage
